// File: vlog.f
source/mem_pkg.sv
source/mem_read_port.sv
source/mem_arb.sv
source/sram_rd.sv
source/mem_sys_top.sv
sim/tb_mem_checks.sv
sim/tb_mem_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory read path testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_mem_sys \
  -f vlog.f

./obj_dir/Vtb_mem_sys | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0

// File: sim/tb_mem_sys.sv
module tb_mem_sys;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_pkg::*;

  localparam int DEPTH_WORDS = DEF_DEPTH_WORDS;
  localparam int RD_LAT      = DEF_RD_LAT;

  // read counts per test
  localparam int N_SEQ   = 8;
  localparam int N_MIX   = 24;
  localparam int N_BOTH  = 12;
  localparam int N_STALL = 8;
  localparam int N_OOR   = 3;
  localparam int N_TOTAL = N_SEQ + 2 * N_MIX + 2 * N_BOTH + 4 * N_STALL + N_OOR;
  localparam int WD_CYCLES = N_TOTAL * (RD_LAT + 12) * 2 + 16 + DEPTH_WORDS + 8;

  logic    clk;
  logic    rstn;
  logic    ifu_req_valid;
  logic    ifu_req_ready;
  rd_req_t ifu_req;
  logic    ifu_rsp_valid;
  logic    ifu_rsp_ready;
  rd_rsp_t ifu_rsp;
  logic    lsu_req_valid;
  logic    lsu_req_ready;
  rd_req_t lsu_req;
  logic    lsu_rsp_valid;
  logic    lsu_rsp_ready;
  rd_rsp_t lsu_rsp;
  logic    wr_en;
  addr_t   wr_addr;
  data_t   wr_data;

  logic  lat_chk;
  int    ifu_rcv_cnt;
  int    lsu_rcv_cnt;
  int    ifu_sent;
  int    lsu_sent;
  int    seed;
  int    total_errs;
  addr_t addr_tab [2][N_MIX];
  int    gap_tab [2][N_MIX];

  mem_sys_top #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .RD_LAT      (RD_LAT)
  ) dut (
    .clk           (clk),
    .rstn          (rstn),
    .ifu_req_valid (ifu_req_valid),
    .ifu_req_ready (ifu_req_ready),
    .ifu_req       (ifu_req),
    .ifu_rsp_valid (ifu_rsp_valid),
    .ifu_rsp_ready (ifu_rsp_ready),
    .ifu_rsp       (ifu_rsp),
    .lsu_req_valid (lsu_req_valid),
    .lsu_req_ready (lsu_req_ready),
    .lsu_req       (lsu_req),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp       (lsu_rsp),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  tb_mem_checks #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .RD_LAT      (RD_LAT)
  ) u_checks (
    .clk           (clk),
    .rstn          (rstn),
    .lat_chk       (lat_chk),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .ifu_req_valid (ifu_req_valid),
    .ifu_req_ready (ifu_req_ready),
    .ifu_req       (ifu_req),
    .ifu_rsp_valid (ifu_rsp_valid),
    .ifu_rsp_ready (ifu_rsp_ready),
    .ifu_rsp       (ifu_rsp),
    .lsu_req_valid (lsu_req_valid),
    .lsu_req_ready (lsu_req_ready),
    .lsu_req       (lsu_req),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp       (lsu_rsp),
    .arb_state     (dut.u_arb.state),
    .ifu_fwd_valid (dut.ifu_fwd_valid),
    .ifu_fwd_ready (dut.ifu_fwd_ready),
    .lsu_fwd_valid (dut.lsu_fwd_valid),
    .lsu_fwd_ready (dut.lsu_fwd_ready),
    .ifu_rcv_cnt   (ifu_rcv_cnt),
    .lsu_rcv_cnt   (lsu_rcv_cnt)
  );

  always #5 clk = ~clk;

  // preload pattern, mixes every address bit
  function automatic data_t fill_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  task automatic send_req(input logic is_lsu, input addr_t addr);
    @(negedge clk);
    if (is_lsu) begin
      lsu_req_valid = 1'b1;
      lsu_req.addr  = addr;
      while (!lsu_req_ready) @(negedge clk);
      lsu_sent++;
    end else begin
      ifu_req_valid = 1'b1;
      ifu_req.addr  = addr;
      while (!ifu_req_ready) @(negedge clk);
      ifu_sent++;
    end
    // transfer on the edge in between
    @(negedge clk);
    if (is_lsu) begin
      lsu_req_valid = 1'b0;
    end else begin
      ifu_req_valid = 1'b0;
    end
  endtask

  task automatic make_streams(input int n, input int max_gap);
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < n; k++) begin
        addr_tab[p][k] = addr_t'($unsigned($random(seed)) % DEPTH_WORDS) << 2;
        gap_tab[p][k]  = int'($unsigned($random(seed)) % (max_gap + 1));
      end
    end
  endtask

  task automatic run_stream(input logic is_lsu, input int n);
    for (int k = 0; k < n; k++) begin
      repeat (gap_tab[is_lsu][k]) @(negedge clk);
      send_req(is_lsu, addr_tab[is_lsu][k]);
    end
  endtask

  task automatic wait_drain();
    while (ifu_rcv_cnt != ifu_sent || lsu_rcv_cnt != lsu_sent) @(negedge clk);
  endtask

  initial begin
    seed          = 4259;
    clk           = 1'b0;
    rstn          = 1'b0;
    ifu_req_valid = 1'b0;
    ifu_req       = '0;
    ifu_rsp_ready = 1'b1;
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    lsu_rsp_ready = 1'b1;
    wr_en         = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    lat_chk       = 1'b0;
    ifu_sent      = 0;
    lsu_sent      = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    for (int i = 0; i < DEPTH_WORDS; i++) begin
      @(negedge clk);
      wr_en   = 1'b1;
      wr_addr = addr_t'(i * 4);
      wr_data = fill_word(addr_t'(i * 4));
    end
    @(negedge clk);
    wr_en = 1'b0;

    // ifu alone, one read at a time
    lat_chk = 1'b1;
    for (int i = 0; i < N_SEQ; i++) begin
      send_req(1'b0, addr_t'(64 + i * 4));
      wait_drain();
    end
    lat_chk = 1'b0;

    make_streams(N_MIX, 7);
    fork
      run_stream(1'b0, N_MIX);
      run_stream(1'b1, N_MIX);
    join
    wait_drain();

    // both ports back to back
    make_streams(N_BOTH, 0);
    fork
      run_stream(1'b0, N_BOTH);
      run_stream(1'b1, N_BOTH);
    join
    wait_drain();

    // one port at a time holds its response, arbiter stalls
    for (int p = 0; p < 2; p++) begin
      make_streams(N_STALL, 0);
      if (p == 0) begin
        ifu_rsp_ready = 1'b0;
      end else begin
        lsu_rsp_ready = 1'b0;
      end
      fork
        run_stream(1'b0, N_STALL);
        run_stream(1'b1, N_STALL);
        begin
          repeat (60) @(negedge clk);
          ifu_rsp_ready = 1'b1;
          lsu_rsp_ready = 1'b1;
        end
      join
      wait_drain();
    end

    fork
      send_req(1'b1, addr_t'(DEPTH_WORDS * 4));
      send_req(1'b0, addr_t'(12));
    join
    wait_drain();
    send_req(1'b0, 32'hffff_fffc);
    wait_drain();

    repeat (4) @(negedge clk);
    total_errs = u_checks.data_errs + u_checks.lat_errs + u_checks.arb_errs +
                 u_checks.proto_errs;
    $display("errors: data %0d, latency %0d, arbitration %0d, protocol %0d",
             u_checks.data_errs, u_checks.lat_errs, u_checks.arb_errs,
             u_checks.proto_errs);
    if (total_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout: reads still outstanding after %0d cycles", WD_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim/tb_mem_checks.sv
module tb_mem_checks #(
  parameter int DEPTH_WORDS = mem_pkg::DEF_DEPTH_WORDS,
  parameter int RD_LAT      = mem_pkg::DEF_RD_LAT
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 lat_chk,
  input  logic                 wr_en,
  input  mem_pkg::addr_t       wr_addr,
  input  mem_pkg::data_t       wr_data,
  input  logic                 ifu_req_valid,
  input  logic                 ifu_req_ready,
  input  mem_pkg::rd_req_t     ifu_req,
  input  logic                 ifu_rsp_valid,
  input  logic                 ifu_rsp_ready,
  input  mem_pkg::rd_rsp_t     ifu_rsp,
  input  logic                 lsu_req_valid,
  input  logic                 lsu_req_ready,
  input  mem_pkg::rd_req_t     lsu_req,
  input  logic                 lsu_rsp_valid,
  input  logic                 lsu_rsp_ready,
  input  mem_pkg::rd_rsp_t     lsu_rsp,
  input  mem_pkg::arb_state_e  arb_state,
  input  logic                 ifu_fwd_valid,
  input  logic                 ifu_fwd_ready,
  input  logic                 lsu_fwd_valid,
  input  logic                 lsu_fwd_ready,
  output int                   ifu_rcv_cnt,
  output int                   lsu_rcv_cnt
);
  timeunit 1ns;
  timeprecision 100ps;
  import mem_pkg::*;

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam addr_t LIMIT = addr_t'(DEPTH_WORDS * 4);

  // mirror of the preload writes
  data_t   model [DEPTH_WORDS];
  rd_rsp_t ifu_exp_q [$];
  rd_rsp_t lsu_exp_q [$];

  int   data_errs  = 0;
  int   lat_errs   = 0;
  int   arb_errs   = 0;
  int   proto_errs = 0;
  int   cyc        = 0;
  int   ifu_acc_cyc;
  src_e last_grant;

  function automatic rd_rsp_t expect_rsp(addr_t addr);
    rd_rsp_t e;
    if (addr >= LIMIT) begin
      e.data = '0;
      e.resp = SLVERR;
    end else begin
      e.data = model[addr[IDX_W+1:2]];
      e.resp = OKAY;
    end
    return e;
  endfunction

  always @(posedge clk) begin
    rd_rsp_t exp_v;
    src_e    granted;
    if (!rstn) begin
      // pointer starts on ifu, as if lsu had the last grant
      last_grant  = SRC_LSU;
      ifu_rcv_cnt = 0;
      lsu_rcv_cnt = 0;
    end else begin
      if (wr_en && wr_addr < LIMIT) begin
        model[wr_addr[IDX_W+1:2]] = wr_data;
      end
      if (ifu_req_valid && ifu_req_ready) begin
        ifu_exp_q.push_back(expect_rsp(ifu_req.addr));
        ifu_acc_cyc = cyc;
      end
      if (lsu_req_valid && lsu_req_ready) begin
        lsu_exp_q.push_back(expect_rsp(lsu_req.addr));
      end

      if (ifu_rsp_valid && ifu_rsp_ready) begin
        ifu_rcv_cnt++;
        a_ifu_pending: assert (ifu_exp_q.size() != 0) else begin
          proto_errs++;
          $display("** Error at %0t: ifu response with no read outstanding", $time);
        end
        if (ifu_exp_q.size() != 0) begin
          exp_v = ifu_exp_q.pop_front();
          a_ifu_data: assert (ifu_rsp == exp_v) else begin
            data_errs++;
            $display("** Error at %0t: ifu_rsp expected %h got %h", $time, exp_v, ifu_rsp);
          end
        end
        // valid RD_LAT+4 after accept, taken on the next edge
        if (lat_chk) begin
          a_ifu_lat: assert (cyc == ifu_acc_cyc + RD_LAT + 5) else begin
            lat_errs++;
            $display("** Error at %0t: ifu_rsp_valid latency expected %0d got %0d",
                     $time, RD_LAT + 4, cyc - ifu_acc_cyc - 1);
          end
        end
      end

      if (lsu_rsp_valid && lsu_rsp_ready) begin
        lsu_rcv_cnt++;
        a_lsu_pending: assert (lsu_exp_q.size() != 0) else begin
          proto_errs++;
          $display("** Error at %0t: lsu response with no read outstanding", $time);
        end
        if (lsu_exp_q.size() != 0) begin
          exp_v = lsu_exp_q.pop_front();
          a_lsu_data: assert (lsu_rsp == exp_v) else begin
            data_errs++;
            $display("** Error at %0t: lsu_rsp expected %h got %h", $time, exp_v, lsu_rsp);
          end
        end
      end

      // grant happens on a fwd transfer in idle
      if (arb_state == ARB_IDLE &&
          ((ifu_fwd_valid && ifu_fwd_ready) || (lsu_fwd_valid && lsu_fwd_ready))) begin
        granted = (ifu_fwd_valid && ifu_fwd_ready) ? SRC_IFU : SRC_LSU;
        if (ifu_fwd_valid && lsu_fwd_valid) begin
          a_rr_turn: assert (granted != last_grant) else begin
            arb_errs++;
            $display("** Error at %0t: grant expected %s got %s", $time,
                     (last_grant == SRC_IFU) ? "lsu" : "ifu",
                     (granted == SRC_IFU) ? "ifu" : "lsu");
          end
        end
        last_grant = granted;
      end
    end
    cyc++;
  end

  a_reset_idle: assert property (
    @(posedge clk)
    $rose(rstn) |-> ifu_req_ready && lsu_req_ready && !ifu_rsp_valid && !lsu_rsp_valid
  ) else begin
    proto_errs++;
    $display("** Error at %0t: ports not idle right after reset", $time);
  end

  a_ifu_rsp_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    ifu_rsp_valid && !ifu_rsp_ready |=> ifu_rsp_valid && $stable(ifu_rsp)
  ) else begin
    proto_errs++;
    $display("** Error at %0t: ifu response dropped or changed while stalled", $time);
  end

  a_lsu_rsp_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    lsu_rsp_valid && !lsu_rsp_ready |=> lsu_rsp_valid && $stable(lsu_rsp)
  ) else begin
    proto_errs++;
    $display("** Error at %0t: lsu response dropped or changed while stalled", $time);
  end

endmodule

// File: source/mem_sys_top.sv
module mem_sys_top #(
  parameter int DEPTH_WORDS = mem_pkg::DEF_DEPTH_WORDS,
  parameter int RD_LAT      = mem_pkg::DEF_RD_LAT
) (
  input  logic             clk,
  input  logic             rstn,

  // instruction fetch
  input  logic             ifu_req_valid,
  output logic             ifu_req_ready,
  input  mem_pkg::rd_req_t ifu_req,
  output logic             ifu_rsp_valid,
  input  logic             ifu_rsp_ready,
  output mem_pkg::rd_rsp_t ifu_rsp,

  // load/store
  input  logic             lsu_req_valid,
  output logic             lsu_req_ready,
  input  mem_pkg::rd_req_t lsu_req,
  output logic             lsu_rsp_valid,
  input  logic             lsu_rsp_ready,
  output mem_pkg::rd_rsp_t lsu_rsp,

  // preload
  input  logic             wr_en,
  input  mem_pkg::addr_t   wr_addr,
  input  mem_pkg::data_t   wr_data
);
  import mem_pkg::*;

  logic    ifu_fwd_valid;
  logic    ifu_fwd_ready;
  rd_req_t ifu_fwd_req;
  logic    ifu_ret_valid;
  logic    ifu_ret_ready;
  rd_rsp_t ifu_ret_rsp;

  logic    lsu_fwd_valid;
  logic    lsu_fwd_ready;
  rd_req_t lsu_fwd_req;
  logic    lsu_ret_valid;
  logic    lsu_ret_ready;
  rd_rsp_t lsu_ret_rsp;

  logic    ar_valid;
  logic    ar_ready;
  rd_req_t ar;
  logic    r_valid;
  logic    r_ready;
  rd_rsp_t r;

  mem_read_port u_ifu_port (
    .clk       (clk),
    .rstn      (rstn),
    .req_valid (ifu_req_valid),
    .req_ready (ifu_req_ready),
    .req       (ifu_req),
    .rsp_valid (ifu_rsp_valid),
    .rsp_ready (ifu_rsp_ready),
    .rsp       (ifu_rsp),
    .fwd_valid (ifu_fwd_valid),
    .fwd_ready (ifu_fwd_ready),
    .fwd_req   (ifu_fwd_req),
    .ret_valid (ifu_ret_valid),
    .ret_ready (ifu_ret_ready),
    .ret_rsp   (ifu_ret_rsp)
  );

  mem_read_port u_lsu_port (
    .clk       (clk),
    .rstn      (rstn),
    .req_valid (lsu_req_valid),
    .req_ready (lsu_req_ready),
    .req       (lsu_req),
    .rsp_valid (lsu_rsp_valid),
    .rsp_ready (lsu_rsp_ready),
    .rsp       (lsu_rsp),
    .fwd_valid (lsu_fwd_valid),
    .fwd_ready (lsu_fwd_ready),
    .fwd_req   (lsu_fwd_req),
    .ret_valid (lsu_ret_valid),
    .ret_ready (lsu_ret_ready),
    .ret_rsp   (lsu_ret_rsp)
  );

  mem_arb u_arb (
    .clk           (clk),
    .rstn          (rstn),
    .ifu_fwd_valid (ifu_fwd_valid),
    .ifu_fwd_ready (ifu_fwd_ready),
    .ifu_fwd_req   (ifu_fwd_req),
    .lsu_fwd_valid (lsu_fwd_valid),
    .lsu_fwd_ready (lsu_fwd_ready),
    .lsu_fwd_req   (lsu_fwd_req),
    .ifu_ret_valid (ifu_ret_valid),
    .ifu_ret_ready (ifu_ret_ready),
    .ifu_ret_rsp   (ifu_ret_rsp),
    .lsu_ret_valid (lsu_ret_valid),
    .lsu_ret_ready (lsu_ret_ready),
    .lsu_ret_rsp   (lsu_ret_rsp),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .ar            (ar),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .r             (r)
  );

  sram_rd #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .RD_LAT      (RD_LAT)
  ) u_sram (
    .clk      (clk),
    .rstn     (rstn),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
  );

endmodule

// File: source/sram_rd.sv
module sram_rd #(
  parameter int DEPTH_WORDS = mem_pkg::DEF_DEPTH_WORDS,
  parameter int RD_LAT      = mem_pkg::DEF_RD_LAT
) (
  input  logic             clk,
  input  logic             rstn,

  // preload
  input  logic             wr_en,
  input  mem_pkg::addr_t   wr_addr,
  input  mem_pkg::data_t   wr_data,

  // read channel
  input  logic             ar_valid,
  output logic             ar_ready,
  input  mem_pkg::rd_req_t ar,
  output logic             r_valid,
  input  logic             r_ready,
  output mem_pkg::rd_rsp_t r
);
  import mem_pkg::*;

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam int CNT_W = (RD_LAT > 1) ? $clog2(RD_LAT) : 1;
  localparam addr_t LIMIT = addr_t'(DEPTH_WORDS * 4);

  data_t mem [DEPTH_WORDS];

  logic             busy;
  logic [CNT_W-1:0] cnt;
  rd_rsp_t          r_q;
  logic             ar_fire;

  assign ar_fire  = ar_valid && ar_ready;
  assign ar_ready = !busy;
  assign r        = r_q;

  // word addressed, byte address drops its low two bits
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < LIMIT)) begin
      mem[wr_addr[IDX_W+1:2]] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (ar.addr < LIMIT) begin
        r_q <= '{data: mem[ar.addr[IDX_W+1:2]], resp: OKAY};
      end else begin
        r_q <= '{data: '0, resp: SLVERR};
      end
    end
  end

  // latency countdown, then hold until taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      cnt     <= '0;
      r_valid <= 1'b0;
    end else begin
      if (ar_fire) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(RD_LAT - 1);
      end else if (busy && !r_valid) begin
        if (cnt == '0) begin
          r_valid <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
        busy    <= 1'b0;
      end
    end
  end

  // r_valid is first sampled high one edge after it rises
  a_r_after_ar: assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(r_valid) |-> $past(ar_fire, RD_LAT + 1)
  );

endmodule

// File: source/mem_arb.sv
module mem_arb (
  input  logic             clk,
  input  logic             rstn,

  // requests from the read ports
  input  logic             ifu_fwd_valid,
  output logic             ifu_fwd_ready,
  input  mem_pkg::rd_req_t ifu_fwd_req,
  input  logic             lsu_fwd_valid,
  output logic             lsu_fwd_ready,
  input  mem_pkg::rd_req_t lsu_fwd_req,

  // responses to the read ports
  output logic             ifu_ret_valid,
  input  logic             ifu_ret_ready,
  output mem_pkg::rd_rsp_t ifu_ret_rsp,
  output logic             lsu_ret_valid,
  input  logic             lsu_ret_ready,
  output mem_pkg::rd_rsp_t lsu_ret_rsp,

  // sram read channel
  output logic             ar_valid,
  input  logic             ar_ready,
  output mem_pkg::rd_req_t ar,
  input  logic             r_valid,
  output logic             r_ready,
  input  mem_pkg::rd_rsp_t r
);
  import mem_pkg::*;

  arb_state_e state;
  src_e       rr_ptr;
  src_e       owner;
  src_e       grant;
  rd_req_t    ar_q;
  rd_rsp_t    rsp_q;

  logic any_req;
  logic fwd_fire;
  logic owner_ret_ready;

  assign any_req  = ifu_fwd_valid || lsu_fwd_valid;
  assign fwd_fire = (state == ARB_IDLE) && any_req;

  // rr_ptr names the preferred source when both ask
  always_comb begin
    if (ifu_fwd_valid && lsu_fwd_valid) begin
      grant = rr_ptr;
    end else if (lsu_fwd_valid) begin
      grant = SRC_LSU;
    end else begin
      grant = SRC_IFU;
    end
  end

  assign ifu_fwd_ready = (state == ARB_IDLE) && (grant == SRC_IFU);
  assign lsu_fwd_ready = (state == ARB_IDLE) && (grant == SRC_LSU);

  assign ar_valid = (state == ARB_ADDR);
  assign ar       = ar_q;
  assign r_ready  = (state == ARB_WAIT);

  // data goes to both, valid only to the owner
  assign ifu_ret_valid = (state == ARB_RESP) && (owner == SRC_IFU);
  assign lsu_ret_valid = (state == ARB_RESP) && (owner == SRC_LSU);
  assign ifu_ret_rsp   = rsp_q;
  assign lsu_ret_rsp   = rsp_q;

  assign owner_ret_ready = (owner == SRC_IFU) ? ifu_ret_ready : lsu_ret_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= ARB_IDLE;
      rr_ptr <= SRC_IFU;
      owner  <= SRC_IFU;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (any_req) begin
            owner  <= grant;
            rr_ptr <= (grant == SRC_IFU) ? SRC_LSU : SRC_IFU;
            state  <= ARB_ADDR;
          end
        end
        ARB_ADDR: begin
          if (ar_ready) begin
            state <= ARB_WAIT;
          end
        end
        ARB_WAIT: begin
          if (r_valid) begin
            state <= ARB_RESP;
          end
        end
        ARB_RESP: begin
          // stalls here while the owner still holds its last response
          if (owner_ret_ready) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fwd_fire) begin
      ar_q <= (grant == SRC_IFU) ? ifu_fwd_req : lsu_fwd_req;
    end
    if (r_valid && r_ready) begin
      rsp_q <= r;
    end
  end

  // a stalled response keeps its owner and data
  a_ret_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    (ifu_ret_valid && !ifu_ret_ready) || (lsu_ret_valid && !lsu_ret_ready) |=>
      $stable(ifu_ret_valid) && $stable(lsu_ret_valid) && $stable(ifu_ret_rsp)
  );

  // every sram read starts from a granted port request
  a_ar_after_grant: assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(ar_valid) |->
      $past((ifu_fwd_valid && ifu_fwd_ready) || (lsu_fwd_valid && lsu_fwd_ready))
  );

endmodule

// File: source/mem_read_port.sv
module mem_read_port (
  input  logic             clk,
  input  logic             rstn,

  // requester side
  input  logic             req_valid,
  output logic             req_ready,
  input  mem_pkg::rd_req_t req,
  output logic             rsp_valid,
  input  logic             rsp_ready,
  output mem_pkg::rd_rsp_t rsp,

  // arbiter side
  output logic             fwd_valid,
  input  logic             fwd_ready,
  output mem_pkg::rd_req_t fwd_req,
  input  logic             ret_valid,
  output logic             ret_ready,
  input  mem_pkg::rd_rsp_t ret_rsp
);
  import mem_pkg::*;

  logic    req_full;
  logic    rsp_full;
  rd_req_t req_q;
  rd_rsp_t rsp_q;

  logic req_fire;
  logic fwd_fire;
  logic ret_fire;
  logic rsp_fire;

  assign req_fire = req_valid && req_ready;
  assign fwd_fire = fwd_valid && fwd_ready;
  assign ret_fire = ret_valid && ret_ready;
  assign rsp_fire = rsp_valid && rsp_ready;

  // one slot each way, so a new request can wait behind an unclaimed response
  assign req_ready = !req_full;
  assign fwd_valid = req_full;
  assign fwd_req   = req_q;

  // holding a response back-pressures the arbiter
  assign ret_ready = !rsp_full;
  assign rsp_valid = rsp_full;
  assign rsp       = rsp_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      req_full <= 1'b0;
      rsp_full <= 1'b0;
    end else begin
      if (req_fire) begin
        req_full <= 1'b1;
      end else if (fwd_fire) begin
        req_full <= 1'b0;
      end

      if (ret_fire) begin
        rsp_full <= 1'b1;
      end else if (rsp_fire) begin
        rsp_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req;
    end
    if (ret_fire) begin
      rsp_q <= ret_rsp;
    end
  end

  a_fwd_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    fwd_valid && !fwd_ready |=> fwd_valid && $stable(fwd_req)
  );

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // top level defaults
  localparam int DEF_DEPTH_WORDS = 256;
  // read latency in cycles, must be at least 1
  localparam int DEF_RD_LAT = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // same encoding as axi rresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } rd_rsp_t;

  // owner of the outstanding sram read
  typedef enum logic {
    SRC_IFU = 1'b0,
    SRC_LSU = 1'b1
  } src_e;

  typedef enum logic [1:0] {
    ARB_IDLE = 2'b00,
    ARB_ADDR = 2'b01,
    ARB_WAIT = 2'b10,
    ARB_RESP = 2'b11
  } arb_state_e;

endpackage
